//--- logic/dcfeb_cfg.svh
`ifndef DCFEB_CFG_SVH
`define DCFEB_CFG_SVH

////////////////////////////////////////////////////////////
// Front end geometry
////////////////////////////////////////////////////////////

`define DCFEB_N_CHAN       4    // Serial ADC channels on the chip
`define DCFEB_SAMPLE_BITS  12   // Sent LSB first
`define DCFEB_PIPE_SIZE    128  // Frames in the circular buffer
`define DCFEB_L1A_SAMPLES  8    // Frames captured per trigger
`define DCFEB_FIFO_SIZE    16   // Two full events

////////////////////////////////////////////////////////////
// Host function codes
////////////////////////////////////////////////////////////

`define DCFEB_FN_READ       8'h06
`define DCFEB_FN_RESTART    8'h0F
`define DCFEB_FN_DEPTH      8'h10
`define DCFEB_FN_SLIP_ODD   8'h11
`define DCFEB_FN_SLIP_EVEN  8'h12

`endif

//--- logic/adc_pkg.sv
`include "dcfeb_cfg.svh"

package adc_pkg;

	// One conversion from one channel
	typedef logic [`DCFEB_SAMPLE_BITS-1:0] adc_sample_t;

	// All channels at one sampling instant, channel 0 in the low bits
	typedef struct packed {
		adc_sample_t [`DCFEB_N_CHAN-1:0] ch;
	} adc_frame_t;

endpackage

//--- logic/cmd_pkg.sv
package cmd_pkg;

	import adc_pkg::*;

	// Host request, held stable while cmd_req is high
	typedef struct packed {
		logic [7:0] fn;   // Function code
		logic [7:0] arg;  // Only set depth uses it
	} cmd_req_t;

	// Response, valid while cmd_ack is high
	typedef struct packed {
		logic       empty;  // No frame was waiting
		adc_frame_t data;
	} cmd_rsp_t;

endpackage

//--- logic/adc_deser.sv
`include "dcfeb_cfg.svh"

module adc_deser import adc_pkg::*; (
	input  logic                     cms_clk,
	input  logic                     rst_n,
	input  logic [`DCFEB_N_CHAN-1:0] adc_ser,
	input  logic                     slip_odd,
	input  logic                     slip_even,
	output adc_frame_t               frame,
	output logic                     frame_valid
);

	localparam int LAST_BIT = `DCFEB_SAMPLE_BITS - 1;
	localparam int CW = $clog2(`DCFEB_SAMPLE_BITS);

	logic [1:0]                      slip;     // Index 0 even group, 1 odd group
	logic [1:0]                      done;     // Group boundary at this edge
	logic [1:0][CW-1:0]              bit_cnt;
	adc_sample_t [`DCFEB_N_CHAN-1:0] shreg;

	assign slip = {slip_odd, slip_even};

	always_comb begin
		for (int g = 0; g < 2; g++) begin
			done[g] = (bit_cnt[g] == CW'(LAST_BIT)) && !slip[g];
		end
	end

	// A slip freezes the group counter for one edge,
	// so every later word starts one bit later
	always_ff @(posedge cms_clk) begin
		if (!rst_n) begin
			bit_cnt <= '0;
		end else begin
			for (int g = 0; g < 2; g++) begin
				if (!slip[g])
					bit_cnt[g] <= done[g] ? '0 : bit_cnt[g] + 1'b1;
			end
		end
	end

	// LSB arrives first, so new bits enter at the top
	always_ff @(posedge cms_clk) begin
		for (int c = 0; c < `DCFEB_N_CHAN; c++) begin
			shreg[c] <= {adc_ser[c], shreg[c][LAST_BIT:1]};
			if (done[c % 2])
				frame.ch[c] <= {adc_ser[c], shreg[c][LAST_BIT:1]};
		end
	end

	// Odd words keep the last complete value until the even group finishes
	always_ff @(posedge cms_clk) begin
		if (!rst_n)
			frame_valid <= 1'b0;
		else
			frame_valid <= done[0];
	end

endmodule

//--- logic/sample_pipeline.sv
`include "dcfeb_cfg.svh"

module sample_pipeline import adc_pkg::*; (
	input  logic                                cms_clk,
	input  logic                                rst_n,
	input  adc_frame_t                          frame,
	input  logic                                frame_valid,
	input  logic [$clog2(`DCFEB_PIPE_SIZE)-1:0] depth,
	input  logic                                restart,
	output adc_frame_t                          delayed,
	output logic                                delayed_valid,
	output logic                                filled
);

	localparam int AW = $clog2(`DCFEB_PIPE_SIZE);
	localparam int FILL_MAX = `DCFEB_PIPE_SIZE + `DCFEB_L1A_SAMPLES - 1;  // Largest depth + 8
	localparam int FW = $clog2(FILL_MAX + 1);

	adc_frame_t    mem [`DCFEB_PIPE_SIZE];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [FW-1:0] fill_cnt;

	assign rd_ptr = wr_ptr - depth;  // Wraps around the buffer

	// Enough history behind the read point for a full capture
	assign filled = fill_cnt >= FW'(depth) + FW'(`DCFEB_L1A_SAMPLES);

	////////////////////////////////////////////////////////////
	// Circular buffer
	////////////////////////////////////////////////////////////

	always_ff @(posedge cms_clk) begin
		if (frame_valid) begin
			mem[wr_ptr] <= frame;
			delayed     <= mem[rd_ptr];  // Written depth frames ago
		end
	end

	always_ff @(posedge cms_clk) begin
		if (!rst_n) begin
			wr_ptr        <= '0;
			delayed_valid <= 1'b0;
			fill_cnt      <= '0;
		end else begin
			delayed_valid <= frame_valid;
			if (frame_valid)
				wr_ptr <= wr_ptr + 1'b1;
			// Frame arriving with the restart is not counted
			if (restart)
				fill_cnt <= '0;
			else if (frame_valid && fill_cnt != FW'(FILL_MAX))
				fill_cnt <= fill_cnt + 1'b1;  // Saturates
		end
	end

	// Depth comes from the command decoder; zero would return the slot being overwritten
	assert property (@(posedge cms_clk) disable iff (!rst_n)
		delayed_valid |-> $past(depth) != '0)
		else $error("pipeline read with depth zero");

endmodule

//--- logic/l1a_capture_fifo.sv
`include "dcfeb_cfg.svh"

module l1a_capture_fifo import adc_pkg::*; (
	input  logic       cms_clk,
	input  logic       rst_n,
	input  logic       l1a,
	input  adc_frame_t delayed,
	input  logic       delayed_valid,
	input  logic       filled,
	input  logic       pop,
	output adc_frame_t head,
	output logic       empty
);

	localparam int AW = $clog2(`DCFEB_FIFO_SIZE);
	localparam int CW = $clog2(`DCFEB_L1A_SAMPLES + 1);
	localparam int ROOM_MAX = `DCFEB_FIFO_SIZE - `DCFEB_L1A_SAMPLES;  // Most entries still fitting an event

	adc_frame_t    mem [`DCFEB_FIFO_SIZE];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0]   count;
	logic [CW-1:0] cap_left;  // Frames still to capture
	logic          full;
	logic          push;
	logic          accept;

	assign full  = int'(count) == `DCFEB_FIFO_SIZE;
	assign empty = count == '0;
	assign head  = mem[rd_ptr];
	assign push  = delayed_valid && cap_left != '0;

	// Trigger dropped while filling, busy, or short of room
	assign accept = l1a && filled && cap_left == '0 && int'(count) <= ROOM_MAX;

	////////////////////////////////////////////////////////////
	// Capture and storage
	////////////////////////////////////////////////////////////

	always_ff @(posedge cms_clk) begin
		if (push)
			mem[wr_ptr] <= delayed;
	end

	always_ff @(posedge cms_clk) begin
		if (!rst_n) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			cap_left <= '0;
		end else begin
			// Frames start with the next valid one after the trigger edge
			if (accept)
				cap_left <= CW'(`DCFEB_L1A_SAMPLES);
			else if (push)
				cap_left <= cap_left - 1'b1;
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + (AW+1)'(push) - (AW+1)'(pop);
		end
	end

	// Room check at L1A time must cover all eight writes; pop gating lives in the decoder
	assert property (@(posedge cms_clk) disable iff (!rst_n) !(push && full))
		else $error("capture write into full FIFO");
	assert property (@(posedge cms_clk) disable iff (!rst_n) !(pop && empty))
		else $error("pop from empty FIFO");

endmodule

//--- logic/fe_cmd_decoder.sv
`include "dcfeb_cfg.svh"

module fe_cmd_decoder import adc_pkg::*, cmd_pkg::*; (
	input  logic                                cms_clk,
	input  logic                                rst_n,
	input  cmd_req_t                            cmd,
	input  logic                                cmd_req,
	output logic                                cmd_ack,
	output cmd_rsp_t                            rsp,
	input  adc_frame_t                          head,
	input  logic                                empty,
	output logic                                slip_odd,
	output logic                                slip_even,
	output logic                                restart,
	output logic                                pop,
	output logic [$clog2(`DCFEB_PIPE_SIZE)-1:0] depth
);

	localparam int AW = $clog2(`DCFEB_PIPE_SIZE);
	localparam logic [AW-1:0] DEPTH_RESET = AW'(64);

	logic accept;
	logic is_read;
	logic set_depth;

	// One edge per request, the same edge that raises ack
	assign accept = cmd_req && !cmd_ack;

	////////////////////////////////////////////////////////////
	// Function decode
	////////////////////////////////////////////////////////////

	assign is_read   = accept && cmd.fn == `DCFEB_FN_READ;
	assign set_depth = accept && cmd.fn == `DCFEB_FN_DEPTH;
	assign restart   = accept && cmd.fn == `DCFEB_FN_RESTART;
	assign slip_odd  = accept && cmd.fn == `DCFEB_FN_SLIP_ODD;
	assign slip_even = accept && cmd.fn == `DCFEB_FN_SLIP_EVEN;
	assign pop       = is_read && !empty;  // Head is latched below at this edge

	always_ff @(posedge cms_clk) begin
		if (!rst_n) begin
			cmd_ack <= 1'b0;
			depth   <= DEPTH_RESET;
		end else begin
			if (accept)
				cmd_ack <= 1'b1;
			else if (!cmd_req)
				cmd_ack <= 1'b0;  // Fourth phase
			if (set_depth)
				depth <= cmd.arg[AW-1:0];
		end
	end

	// Read response holds until the next read
	always_ff @(posedge cms_clk) begin
		if (is_read) begin
			rsp.empty <= empty;
			rsp.data  <= empty ? '0 : head;
		end
	end

	// Host keeps the request word steady while req stays up
	assert property (@(posedge cms_clk) disable iff (!rst_n)
		cmd_req && $past(cmd_req) |-> $stable(cmd))
		else $error("cmd changed during a request");

endmodule

//--- logic/dcfeb_top.sv
`include "dcfeb_cfg.svh"

module dcfeb_top import adc_pkg::*, cmd_pkg::*; (
	input  logic                     cms_clk,
	input  logic                     rst_n,
	input  logic [`DCFEB_N_CHAN-1:0] adc_ser,
	input  logic                     l1a,
	input  cmd_req_t                 cmd,
	input  logic                     cmd_req,
	output logic                     cmd_ack,
	output cmd_rsp_t                 rsp
);

	adc_frame_t frame;
	adc_frame_t delayed;
	adc_frame_t head;
	logic       frame_valid;
	logic       delayed_valid;
	logic       filled;
	logic       empty;
	logic       slip_odd;
	logic       slip_even;
	logic       restart;
	logic       pop;
	logic [$clog2(`DCFEB_PIPE_SIZE)-1:0] depth;

	// Host command port
	fe_cmd_decoder u_decoder (
		.cms_clk   (cms_clk),
		.rst_n     (rst_n),
		.cmd       (cmd),
		.cmd_req   (cmd_req),
		.cmd_ack   (cmd_ack),
		.rsp       (rsp),
		.head      (head),
		.empty     (empty),
		.slip_odd  (slip_odd),
		.slip_even (slip_even),
		.restart   (restart),
		.pop       (pop),
		.depth     (depth)
	);

	adc_deser u_deser (
		.cms_clk     (cms_clk),
		.rst_n       (rst_n),
		.adc_ser     (adc_ser),
		.slip_odd    (slip_odd),
		.slip_even   (slip_even),
		.frame       (frame),
		.frame_valid (frame_valid)
	);

	sample_pipeline u_pipeline (
		.cms_clk       (cms_clk),
		.rst_n         (rst_n),
		.frame         (frame),
		.frame_valid   (frame_valid),
		.depth         (depth),
		.restart       (restart),
		.delayed       (delayed),
		.delayed_valid (delayed_valid),
		.filled        (filled)
	);

	// Trigger capture and readout buffer
	l1a_capture_fifo u_fifo (
		.cms_clk       (cms_clk),
		.rst_n         (rst_n),
		.l1a           (l1a),
		.delayed       (delayed),
		.delayed_valid (delayed_valid),
		.filled        (filled),
		.pop           (pop),
		.head          (head),
		.empty         (empty)
	);

endmodule

//--- bench/tb_dcfeb.sv
`include "dcfeb_cfg.svh"

module tb_dcfeb import adc_pkg::*, cmd_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int N_VEC = 4 * `DCFEB_N_CHAN + 3;  // Words, depth, odd slips, even slips

	logic                     cms_clk;
	logic                     rst_n;
	logic [`DCFEB_N_CHAN-1:0] adc_ser;
	logic                     l1a;
	cmd_req_t                 cmd;
	logic                     cmd_req;
	logic                     cmd_ack;
	cmd_rsp_t                 rsp;
	cmd_rsp_t                 got_rsp;  // Response seen while ack was high

	logic [11:0] vec [0:N_VEC-1];
	logic [31:0] seed = 32'h929c;
	int          checks = 0;
	int          errors = 0;
	int          test_start = 0;
	logic        timed_out = 1'b0;

	// Reference model state
	int          m_edge;        // Edges sampled since reset release
	int          n_frames;      // Frames completed by the deserializer
	int          wr_frames;     // Frames written into the pipeline
	int          wr_cnt;        // Writes since reset or restart
	int          cap_left;
	int          g_cnt [2];     // Bit position per group
	logic [6:0]  m_depth;
	logic        req_taken;
	logic        fv_pend;
	logic        dv_pend;
	adc_frame_t  dly_val;
	adc_frame_t  m_word;
	adc_frame_t  hist [$];
	adc_frame_t  exp_q [$];
	logic [48:0] m_rsp;

	dcfeb_top UUT (
		.cms_clk (cms_clk),
		.rst_n   (rst_n),
		.adc_ser (adc_ser),
		.l1a     (l1a),
		.cmd     (cmd),
		.cmd_req (cmd_req),
		.cmd_ack (cmd_ack),
		.rsp     (rsp)
	);

	initial begin
		cms_clk = 1'b0;
		forever #5 cms_clk = ~cms_clk;
	end

	// Word w of channel c, with a running offset so frames never repeat
	function automatic logic stream_bit(int c, int n);
		logic [11:0] w;
		w = vec[c * 4 + (n / 12) % 4] + 12'(n / 12);
		return w[n % 12];
	endfunction

	function automatic logic [31:0] lcg_next(logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// Next edge samples bit m_edge
	always @(negedge cms_clk) begin
		for (int c = 0; c < `DCFEB_N_CHAN; c++)
			adc_ser[c] <= stream_bit(c, m_edge);
	end

	////////////////////////////////////////////////////////////
	// Reference model, one step per rising edge
	////////////////////////////////////////////////////////////

	always @(posedge cms_clk) begin : model
		logic       acc;
		logic       take_l1a;
		logic [1:0] slip;
		logic [1:0] done;
		if (!rst_n) begin
			m_edge    = 0;
			n_frames  = 0;
			wr_frames = 0;
			wr_cnt    = 0;
			cap_left  = 0;
			g_cnt[0]  = 0;
			g_cnt[1]  = 0;
			m_depth   = 7'd64;
			req_taken = 1'b0;
			fv_pend   = 1'b0;
			dv_pend   = 1'b0;
			hist.delete();
			exp_q.delete();
		end else begin
			acc = cmd_req && !req_taken;  // Ack edge of a new request
			if (acc)
				req_taken = 1'b1;
			else if (!cmd_req)
				req_taken = 1'b0;
			take_l1a = l1a && wr_cnt >= int'(m_depth) + `DCFEB_L1A_SAMPLES
				&& cap_left == 0 && exp_q.size() <= `DCFEB_FIFO_SIZE - `DCFEB_L1A_SAMPLES;
			if (acc && cmd.fn == `DCFEB_FN_READ) begin
				if (exp_q.size() == 0)
					m_rsp = {1'b1, 48'h0};
				else
					m_rsp = {1'b0, exp_q.pop_front()};
			end
			if (dv_pend && cap_left != 0) begin
				exp_q.push_back(dly_val);
				cap_left--;
			end
			if (take_l1a)
				cap_left = `DCFEB_L1A_SAMPLES;
			if (fv_pend) begin
				dly_val = hist[(wr_frames >= m_depth) ? wr_frames - m_depth : 0];
				wr_frames++;
			end
			dv_pend = fv_pend;
			if (acc && cmd.fn == `DCFEB_FN_RESTART)
				wr_cnt = 0;
			else if (fv_pend && wr_cnt < 1000)
				wr_cnt++;
			if (acc && cmd.fn == `DCFEB_FN_DEPTH)
				m_depth = cmd.arg[6:0];
			slip[0] = acc && cmd.fn == `DCFEB_FN_SLIP_EVEN;
			slip[1] = acc && cmd.fn == `DCFEB_FN_SLIP_ODD;
			for (int g = 0; g < 2; g++) begin
				done[g] = g_cnt[g] == 11 && !slip[g];
				if (!slip[g])
					g_cnt[g] = done[g] ? 0 : g_cnt[g] + 1;
			end
			// Last twelve bits form the word
			for (int c = 0; c < `DCFEB_N_CHAN; c++) begin
				if (done[c % 2]) begin
					for (int k = 0; k < 12; k++)
						m_word.ch[c][k] = stream_bit(c, m_edge - 11 + k);
				end
			end
			if (done[0]) begin
				hist.push_back(m_word);
				n_frames++;
			end
			fv_pend = done[0];
			m_edge++;
		end
	end

	////////////////////////////////////////////////////////////
	// Tasks
	////////////////////////////////////////////////////////////

	task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("Error: %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic note_timeout(input string what);
		if (!timed_out)
			$display("Timeout while waiting for %s, the DUT stopped responding", what);
		timed_out = 1'b1;
	endtask

	task automatic end_test(input string name);
		$display("%s: %s, %0d errors", name,
			(errors == test_start) ? "ok" : "FAILED", errors - test_start);
		test_start = errors;
	endtask

	// Four-phase exchange
	task automatic send_cmd(input logic [7:0] fn, input logic [7:0] arg);
		int t;
		@(negedge cms_clk);
		cmd.fn  = fn;
		cmd.arg = arg;
		cmd_req = 1'b1;
		t = 0;
		while (!cmd_ack && !timed_out) begin
			@(negedge cms_clk);
			t++;
			if (t > 50)
				note_timeout("cmd_ack to rise");
		end
		got_rsp = rsp;
		cmd_req = 1'b0;
		t = 0;
		while (cmd_ack && !timed_out) begin
			@(negedge cms_clk);
			t++;
			if (t > 50)
				note_timeout("cmd_ack to fall");
		end
	endtask

	task automatic read_check(input string name);
		send_cmd(`DCFEB_FN_READ, 8'h00);
		check(name, 64'(m_rsp), 64'(got_rsp));
	endtask

	task automatic pulse_l1a();
		@(negedge cms_clk);
		l1a = 1'b1;
		@(negedge cms_clk);
		l1a = 1'b0;
	endtask

	task automatic wait_filled();
		int t;
		t = 0;
		while (wr_cnt < int'(m_depth) + `DCFEB_L1A_SAMPLES && !timed_out) begin
			@(negedge cms_clk);
			t++;
			if (t > 4000)
				note_timeout("the pipeline to fill");
		end
		seed = lcg_next(seed);
		repeat (seed[19:16]) @(negedge cms_clk);  // Random trigger edge
	endtask

	task automatic wait_capture();
		int t;
		t = 0;
		while (cap_left != 0 && !timed_out) begin
			@(negedge cms_clk);
			t++;
			if (t > 500)
				note_timeout("the L1A capture to finish");
		end
	endtask

	task automatic wait_frames(input int n);
		int t;
		int target;
		t = 0;
		target = n_frames + n;
		while (n_frames < target && !timed_out) begin
			@(negedge cms_clk);
			t++;
			if (t > 20 * n + 50)
				note_timeout("deserialized frames");
		end
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////

	initial begin
		$readmemh("bench/dcfeb_vectors.hex", vec);
		rst_n   = 1'b0;
		adc_ser = '0;
		l1a     = 1'b0;
		cmd     = '0;
		cmd_req = 1'b0;
		repeat (16) @(posedge cms_clk);
		@(negedge cms_clk);
		rst_n = 1'b1;

		check("reset ack", 64'(0), 64'(cmd_ack));
		read_check("reset read");
		end_test("reset state");

		send_cmd(`DCFEB_FN_DEPTH, 8'(vec[16]));
		send_cmd(`DCFEB_FN_RESTART, 8'h00);
		wait_filled();
		pulse_l1a();
		wait_capture();
		for (int i = 0; i < 8; i++)
			read_check("depth frame");
		end_test("depth readout");

		read_check("empty read");
		check("empty flag", 64'(1), 64'(got_rsp.empty));
		end_test("empty read");

		send_cmd(`DCFEB_FN_RESTART, 8'h00);
		pulse_l1a();  // Before depth+8 writes
		wait_frames(20);
		read_check("early l1a read");
		check("early l1a empty", 64'(1), 64'(got_rsp.empty));
		end_test("early l1a");

		wait_filled();
		pulse_l1a();
		wait_capture();
		pulse_l1a();
		wait_capture();
		pulse_l1a();  // No room left
		wait_frames(10);
		for (int i = 0; i < 16; i++)
			read_check("full fifo frame");
		check("full fifo depth", 64'(0), 64'(got_rsp.empty));
		read_check("full fifo empty");
		check("full fifo drained", 64'(1), 64'(got_rsp.empty));
		end_test("full fifo");

		for (int i = 0; i < vec[17]; i++)
			send_cmd(`DCFEB_FN_SLIP_ODD, 8'h00);
		for (int i = 0; i < vec[18]; i++)
			send_cmd(`DCFEB_FN_SLIP_EVEN, 8'h00);
		send_cmd(`DCFEB_FN_RESTART, 8'h00);
		wait_filled();
		pulse_l1a();
		wait_capture();
		for (int i = 0; i < 8; i++)
			read_check("slip frame");
		end_test("bit slip");

		$display("Checks %0d, errors %0d, timeout %0d", checks, errors, timed_out);
		if (errors == 0 && !timed_out)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

//--- bench/dcfeb_vectors.hex
// Entries 0-15: four sample words per channel, channel c at 4*c
// Entry 16: pipeline depth, 17: odd slips, 18: even slips
A5C
3F1
7E2
0B9
1D4
C63
852
F0E
2A7
9B8
64C
D31
E05
47A
B96
12F
014
003
005

//--- project.f
+incdir+logic
logic/adc_pkg.sv
logic/cmd_pkg.sv
logic/adc_deser.sv
logic/sample_pipeline.sv
logic/l1a_capture_fifo.sv
logic/fe_cmd_decoder.sv
logic/dcfeb_top.sv
bench/tb_dcfeb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_dcfeb
RTL_TOP   ?= dcfeb_top
FILELIST  ?= project.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD)

sim: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@grep -q "Test passed" $(LOG) || { echo "Simulation did not finish"; exit 1; }

clean:
	rm -rf $(BUILD) $(LOG)
